//--- files.f
+incdir+hw
hw/micro_uart_pkg.sv
hw/micro_uart_fifo.sv
hw/micro_uart_bit_timer.sv
hw/micro_uart_tx_fsm.sv
hw/micro_uart_tx_shifter.sv
hw/micro_uart_rx_fsm.sv
hw/micro_uart_rx_shifter.sv
hw/micro_uart.sv
dv/micro_uart_tb.sv

//--- dv/micro_uart_tb.sv
`include "micro_uart_cfg.svh"

module micro_uart_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int BIT = `MICRO_UART_BIT_CLOCKS;
   localparam int DEPTH = `MICRO_UART_FIFO_DEPTH;
   localparam int LOOP_BYTES = 8;
   localparam int FRAMES = LOOP_BYTES + 4 + 2 + 5;
   // frames, bits per frame, clocks per bit, ns per clock, then doubled.
   localparam longint WATCHDOG_NS = longint'(FRAMES) * 10 * BIT * 10 * 2;

   logic                       clock;
   logic                       clock_sreset;
   logic                       enable_txd;
   logic                       tx_write;
   micro_uart_pkg::uart_byte_t tx_data;
   logic                       rxd;
   logic                       rx_read;
   logic                       tx_full;
   logic                       busy;
   logic                       tx_done;
   logic                       txd;
   logic                       txd_oe;
   micro_uart_pkg::rx_frame_t  rx_frame;
   logic                       rx_valid;
   logic                       rx_overrun;
   logic                       use_bb;
   logic                       bb_line;

   micro_uart_pkg::uart_byte_t tx_q[$];
   micro_uart_pkg::rx_frame_t  rx_q[$];
   micro_uart_pkg::rx_frame_t  exp_rx;
   micro_uart_pkg::uart_byte_t sent;
   logic [9:0]                 cur_frame;
   logic                       exp_overrun;
   int                         tx_pos;
   int                         tx_waiting;
   int                         errors;
   int                         failed_tests;
   int                         mark;

   // txd loops back unless the line driver is in use.
   assign rxd = use_bb ? bb_line : txd;

   micro_uart dut0 (
      .clock(clock), .clock_sreset(clock_sreset), .enable_txd(enable_txd),
      .tx_write(tx_write), .tx_data(tx_data), .rxd(rxd), .rx_read(rx_read),
      .tx_full(tx_full), .busy(busy), .tx_done(tx_done), .txd(txd), .txd_oe(txd_oe),
      .rx_frame(rx_frame), .rx_valid(rx_valid), .rx_overrun(rx_overrun)
   );

   always #5 clock = ~clock;

   function automatic logic frame_bit(input logic [9:0] frame, input int pos);
      return frame[pos / BIT];
   endfunction

   function automatic micro_uart_pkg::uart_byte_t random_byte();
      return 8'($urandom_range(0, 255));
   endfunction

   // models the receive fifo and keeps what the DUT should have stored.
   function automatic void model_receive(input micro_uart_pkg::rx_frame_t frame);
      if (rx_q.size() < DEPTH) begin
         rx_q.push_back(frame);
      end else begin
         exp_overrun = 1'b1;
      end
   endfunction

   // follows each frame on txd and hands its byte to the receive model.
   always @(posedge clock) begin
      if (clock_sreset || !txd_oe) begin
         tx_pos <= 0;
         if (tx_q.size() > 0) begin
            cur_frame <= {1'b1, tx_q[0], 1'b0};
         end
      end else begin
         tx_pos <= tx_pos + 1;
         if (tx_pos == 0) begin
            assert (tx_q.size() > 0) else begin
               $display("t=%0t a frame started with no byte written", $time);
               errors++;
            end
            if (tx_q.size() > 0) begin
               sent = tx_q.pop_front();
               tx_waiting = tx_q.size();
               model_receive({sent, 1'b0});
            end
         end
      end
   end

   idle_line: assert property (@(posedge clock) disable iff (clock_sreset) !txd_oe |-> txd)
      else begin
         $display("FAIL t=%0t txd expected 1 got %0b", $time, $sampled(txd));
         errors++;
      end

   frame_bits: assert property (@(posedge clock) disable iff (clock_sreset)
      txd_oe |-> (txd == frame_bit(cur_frame, tx_pos)))
      else begin
         $display("FAIL t=%0t txd expected %0b got %0b", $time,
                  frame_bit($sampled(cur_frame), $sampled(tx_pos)), $sampled(txd));
         errors++;
      end

   frame_length: assert property (@(posedge clock) disable iff (clock_sreset)
      $fell(txd_oe) |-> (tx_pos == 10 * BIT))
      else begin
         $display("FAIL t=%0t frame_cycles expected %0d got %0d", $time, 10 * BIT,
                  $sampled(tx_pos));
         errors++;
      end

   oe_follows_busy: assert property (@(posedge clock) disable iff (clock_sreset)
      txd_oe == busy)
      else begin
         $display("FAIL t=%0t txd_oe expected %0b got %0b", $time, $sampled(busy),
                  $sampled(txd_oe));
         errors++;
      end

   done_pulse: assert property (@(posedge clock) disable iff (clock_sreset)
      tx_done == $fell(busy))
      else begin
         $display("FAIL t=%0t tx_done expected %0b got %0b", $time, !$sampled(tx_done),
                  $sampled(tx_done));
         errors++;
      end

   start_enabled: assert property (@(posedge clock) disable iff (clock_sreset)
      $rose(txd_oe) |-> $past(enable_txd))
      else begin
         $display("t=%0t a frame started while enable_txd was low", $time);
         errors++;
      end

   back_to_back: assert property (@(posedge clock) disable iff (clock_sreset)
      $fell(txd_oe) && enable_txd && tx_waiting > 0 |=> txd_oe)
      else begin
         $display("t=%0t a queued byte did not follow the previous frame", $time);
         errors++;
      end

   read_value: assert property (@(posedge clock) disable iff (clock_sreset)
      rx_read |-> rx_frame == exp_rx)
      else begin
         $display("FAIL t=%0t rx_frame expected %h got %h", $time, $sampled(exp_rx),
                  $sampled(rx_frame));
         errors++;
      end

   overrun_cause: assert property (@(posedge clock) disable iff (clock_sreset)
      $rose(rx_overrun) |-> exp_overrun)
      else begin
         $display("t=%0t rx_overrun rose while the receive fifo had room", $time);
         errors++;
      end

   overrun_sticky: assert property (@(posedge clock) disable iff (clock_sreset)
      $past(rx_overrun) |-> rx_overrun)
      else begin
         $display("FAIL t=%0t rx_overrun expected 1 got 0", $time);
         errors++;
      end

   task automatic step();
      @(posedge clock);
      #1;
   endtask

   task automatic expect_bit(input string name, input logic actual, input logic expected);
      assert (actual === expected) else begin
         $display("FAIL t=%0t %s expected %0b got %0b", $time, name, expected, actual);
         errors++;
      end
   endtask

   task automatic write_tx(input micro_uart_pkg::uart_byte_t value, input logic kept);
      tx_data = value;
      tx_write = 1'b1;
      if (kept) begin
         tx_q.push_back(value);
         tx_waiting = tx_q.size();
      end
      step();
      tx_write = 1'b0;
   endtask

   task automatic wait_tx_done();
      while (!tx_done) begin
         step();
      end
      step();
   endtask

   task automatic read_rx();
      int guard;
      guard = 0;
      while (!rx_valid && guard < 20 * BIT) begin
         step();
         guard++;
      end
      assert (rx_valid) else begin
         $display("t=%0t no received frame appeared within %0d cycles", $time, guard);
         errors++;
      end
      if (rx_valid) begin
         exp_rx = rx_q.pop_front();
         rx_read = 1'b1;
         step();
         rx_read = 1'b0;
      end
   endtask

   // start bit, data lsb first, chosen stop bit, then one idle bit.
   task automatic bang_frame(input micro_uart_pkg::uart_byte_t value, input logic stop);
      logic [10:0] bits;
      bits = {1'b1, stop, value, 1'b0};
      model_receive({value, ~stop});
      for (int i = 0; i < 11; i++) begin
         bb_line = bits[i];
         repeat (BIT) step();
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == mark) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - mark);
         failed_tests++;
      end
      mark = errors;
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
      $display("Simulation failed");
      $finish;
   end

   initial begin
      clock = 1'b0;
      clock_sreset = 1'b1;
      enable_txd = 1'b0;
      tx_write = 1'b0;
      tx_data = '0;
      rx_read = 1'b0;
      use_bb = 1'b1;
      bb_line = 1'b1;
      exp_rx = '0;
      exp_overrun = 1'b0;
      tx_pos = 0;
      tx_waiting = 0;
      errors = 0;
      failed_tests = 0;
      mark = 0;
      void'($urandom(14));
      repeat (8) @(posedge clock);
      #1;
      clock_sreset = 1'b0;
      use_bb = 1'b0;

      expect_bit("txd", txd, 1'b1);
      expect_bit("txd_oe", txd_oe, 1'b0);
      expect_bit("busy", busy, 1'b0);
      expect_bit("tx_done", tx_done, 1'b0);
      expect_bit("rx_valid", rx_valid, 1'b0);
      expect_bit("tx_full", tx_full, 1'b0);
      expect_bit("rx_overrun", rx_overrun, 1'b0);
      finish_test("reset");

      enable_txd = 1'b1;
      for (int i = 0; i < LOOP_BYTES; i++) begin
         write_tx(random_byte(), 1'b1);
         wait_tx_done();
         read_rx();
      end
      finish_test("loopback");

      enable_txd = 1'b0;
      for (int i = 0; i < 5; i++) begin
         write_tx(random_byte(), i < DEPTH);
         expect_bit("tx_full", tx_full, i >= DEPTH - 1);
      end
      repeat (2 * BIT) step();
      expect_bit("busy", busy, 1'b0);
      enable_txd = 1'b1;
      for (int i = 0; i < DEPTH; i++) begin
         read_rx();
      end
      wait_tx_done();
      expect_bit("tx_full", tx_full, 1'b0);
      expect_bit("rx_valid", rx_valid, 1'b0);
      finish_test("backpressure");

      use_bb = 1'b1;
      bang_frame(random_byte(), 1'b0);
      read_rx();
      bang_frame(random_byte(), 1'b1);
      read_rx();
      use_bb = 1'b0;
      finish_test("framing");

      for (int i = 0; i < 5; i++) begin
         write_tx(random_byte(), 1'b1);
         wait_tx_done();
      end
      for (int i = 0; i < 3 * BIT && !rx_overrun; i++) begin
         step();
      end
      expect_bit("rx_overrun", rx_overrun, 1'b1);
      for (int i = 0; i < DEPTH; i++) begin
         read_rx();
      end
      expect_bit("rx_valid", rx_valid, 1'b0);
      expect_bit("rx_overrun", rx_overrun, 1'b1);
      finish_test("overrun");

      $display("5 tests, %0d failed, %0d errors", failed_tests, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

//--- hw/micro_uart.sv
module micro_uart (
   input  logic                       clock,
   input  logic                       clock_sreset,
   input  logic                       enable_txd,
   input  logic                       tx_write,
   input  micro_uart_pkg::uart_byte_t tx_data,
   input  logic                       rxd,
   input  logic                       rx_read,
   output logic                       tx_full,
   output logic                       busy,
   output logic                       tx_done,
   output logic                       txd,
   output logic                       txd_oe,
   output micro_uart_pkg::rx_frame_t  rx_frame,
   output logic                       rx_valid,
   output logic                       rx_overrun
);

   micro_uart_pkg::uart_byte_t  tx_head;
   logic                        tx_empty;
   logic                        tx_pop;
   logic                        tx_load;
   logic                        tx_run;
   logic                        tx_tick;
   logic                        tx_shift;

   micro_uart_pkg::uart_byte_t  rx_byte;
   micro_uart_pkg::rx_frame_t   rx_wframe;
   micro_uart_pkg::timer_mode_t rx_mode;
   logic                        rx_run;
   logic                        rx_tick;
   logic                        rx_sample;
   logic                        rx_line_bit;
   logic                        rx_push;
   logic                        rx_framing_error;
   logic                        rx_full;
   logic                        rx_empty;

   assign rx_wframe.data          = rx_byte;
   assign rx_wframe.framing_error = rx_framing_error;
   assign rx_valid                = ~rx_empty;

   micro_uart_fifo #(
      .payload_t(micro_uart_pkg::uart_byte_t)
   ) tx_fifo0 (
      .clock       (clock),
      .clock_sreset(clock_sreset),
      .push        (tx_write),
      .wdata       (tx_data),
      .pop         (tx_pop),
      .rdata       (tx_head),
      .full        (tx_full),
      .empty       (tx_empty)
   );

   // transmit bits are always a full period.
   micro_uart_bit_timer tx_timer0 (
      .clock       (clock),
      .clock_sreset(clock_sreset),
      .run         (tx_run),
      .mode        (micro_uart_pkg::TIMER_FULL),
      .tick        (tx_tick)
   );

   micro_uart_tx_fsm tx_fsm0 (
      .clock       (clock),
      .clock_sreset(clock_sreset),
      .enable_txd  (enable_txd),
      .fifo_empty  (tx_empty),
      .tick        (tx_tick),
      .pop         (tx_pop),
      .load        (tx_load),
      .run         (tx_run),
      .shift       (tx_shift),
      .busy        (busy),
      .txd_oe      (txd_oe),
      .tx_done     (tx_done)
   );

   micro_uart_tx_shifter tx_shifter0 (
      .clock       (clock),
      .clock_sreset(clock_sreset),
      .load        (tx_load),
      .shift       (tx_shift),
      .data        (tx_head),
      .txd         (txd)
   );

   micro_uart_bit_timer rx_timer0 (
      .clock       (clock),
      .clock_sreset(clock_sreset),
      .run         (rx_run),
      .mode        (rx_mode),
      .tick        (rx_tick)
   );

   micro_uart_rx_fsm rx_fsm0 (
      .clock        (clock),
      .clock_sreset (clock_sreset),
      .rxd          (rxd),
      .tick         (rx_tick),
      .fifo_full    (rx_full),
      .run          (rx_run),
      .mode         (rx_mode),
      .sample       (rx_sample),
      .line_bit     (rx_line_bit),
      .push         (rx_push),
      .framing_error(rx_framing_error),
      .rx_overrun   (rx_overrun)
   );

   micro_uart_rx_shifter rx_shifter0 (
      .clock       (clock),
      .clock_sreset(clock_sreset),
      .sample      (rx_sample),
      .bit_in      (rx_line_bit),
      .data        (rx_byte)
   );

   micro_uart_fifo #(
      .payload_t(micro_uart_pkg::rx_frame_t)
   ) rx_fifo0 (
      .clock       (clock),
      .clock_sreset(clock_sreset),
      .push        (rx_push),
      .wdata       (rx_wframe),
      .pop         (rx_read),
      .rdata       (rx_frame),
      .full        (rx_full),
      .empty       (rx_empty)
   );

endmodule

//--- hw/micro_uart_rx_shifter.sv
module micro_uart_rx_shifter (
   input  logic                       clock,
   input  logic                       clock_sreset,
   input  logic                       sample,
   input  logic                       bit_in,
   output micro_uart_pkg::uart_byte_t data
);

   micro_uart_pkg::uart_byte_t shift_reg;

   assign data = shift_reg;

   // bits enter at the top, so the first one received ends up in bit 0.
   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         shift_reg <= '0;
      end else if (sample) begin
         shift_reg <= {bit_in, shift_reg[7:1]};
      end
   end

endmodule

//--- hw/micro_uart_rx_fsm.sv
module micro_uart_rx_fsm (
   input  logic                        clock,
   input  logic                        clock_sreset,
   input  logic                        rxd,
   input  logic                        tick,
   input  logic                        fifo_full,
   output logic                        run,
   output micro_uart_pkg::timer_mode_t mode,
   output logic                        sample,
   output logic                        line_bit,
   output logic                        push,
   output logic                        framing_error,
   output logic                        rx_overrun
);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t  state;
   logic [2:0] bit_count;
   logic       rxd_meta;
   logic       rxd_sync;
   logic       rxd_prev;
   logic       start_edge;
   logic       stop_tick;

   assign line_bit   = rxd_sync;
   assign start_edge = rxd_prev & ~rxd_sync;
   assign stop_tick  = (state == RX_STOP) & tick;

   // half a bit lands the first tick mid start bit; full bits after that.
   assign mode = (state == RX_IDLE) ? micro_uart_pkg::TIMER_HALF : micro_uart_pkg::TIMER_FULL;
   assign run  = (state != RX_IDLE);

   assign sample        = (state == RX_DATA) & tick;
   assign framing_error = ~rxd_sync;
   assign push          = stop_tick & ~fifo_full;

   // two flops against metastability, then one more for the edge.
   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         state      <= RX_IDLE;
         bit_count  <= '0;
         rx_overrun <= 1'b0;
      end else begin
         case (state)
            RX_IDLE: begin
               bit_count <= '0;
               if (start_edge) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (tick) begin
                  // a glitch shorter than half a bit is ignored.
                  state <= rxd_sync ? RX_IDLE : RX_DATA;
               end
            end
            RX_DATA: begin
               if (tick) begin
                  bit_count <= bit_count + 1'b1;
                  if (bit_count == 3'd7) begin
                     state <= RX_STOP;
                  end
               end
            end
            RX_STOP: begin
               if (tick) begin
                  // frame is lost when there is no room, flag stays until reset.
                  if (fifo_full) begin
                     rx_overrun <= 1'b1;
                  end
                  state <= RX_IDLE;
               end
            end
            default: begin
               state <= RX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- hw/micro_uart_tx_shifter.sv
module micro_uart_tx_shifter (
   input  logic                     clock,
   input  logic                     clock_sreset,
   input  logic                     load,
   input  logic                     shift,
   input  micro_uart_pkg::uart_byte_t data,
   output logic                     txd
);

   // stop bit, data lsb first, start bit.
   logic [9:0] frame;

   assign txd = frame[0];

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         // idle line is high.
         frame <= '1;
      end else if (load) begin
         frame <= {1'b1, data, 1'b0};
      end else if (shift) begin
         // ones fill in from the top so the line rests high after the stop bit.
         frame <= {1'b1, frame[9:1]};
      end
   end

endmodule

//--- hw/micro_uart_tx_fsm.sv
module micro_uart_tx_fsm (
   input  logic clock,
   input  logic clock_sreset,
   input  logic enable_txd,
   input  logic fifo_empty,
   input  logic tick,
   output logic pop,
   output logic load,
   output logic run,
   output logic shift,
   output logic busy,
   output logic txd_oe,
   output logic tx_done
);

   localparam logic [3:0] LAST_BIT = 4'd9;

   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_t;

   tx_state_t  state;
   logic [3:0] bit_count;
   logic       start;

   // a new frame only starts while enabled; one on the line always finishes.
   assign start = (state == TX_IDLE) & ~fifo_empty & enable_txd;

   assign pop   = start;
   assign load  = start;
   assign run   = (state == TX_SEND);
   assign shift = (state == TX_SEND) & tick;

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         state     <= TX_IDLE;
         bit_count <= '0;
         busy      <= 1'b0;
         txd_oe    <= 1'b0;
         tx_done   <= 1'b0;
      end else begin
         tx_done <= 1'b0;
         case (state)
            TX_IDLE: begin
               bit_count <= '0;
               if (start) begin
                  busy   <= 1'b1;
                  txd_oe <= 1'b1;
                  state  <= TX_SEND;
               end
            end
            TX_SEND: begin
               if (tick) begin
                  bit_count <= bit_count + 1'b1;
                  // tenth tick ends the stop bit.
                  if (bit_count == LAST_BIT) begin
                     busy    <= 1'b0;
                     txd_oe  <= 1'b0;
                     tx_done <= 1'b1;
                     state   <= TX_IDLE;
                  end
               end
            end
            default: begin
               state <= TX_IDLE;
            end
         endcase
      end
   end

endmodule

//--- hw/micro_uart_bit_timer.sv
`include "micro_uart_cfg.svh"

module micro_uart_bit_timer (
   input  logic                      clock,
   input  logic                      clock_sreset,
   input  logic                      run,
   input  micro_uart_pkg::timer_mode_t mode,
   output logic                      tick
);

   localparam int FULL_CLOCKS = `MICRO_UART_BIT_CLOCKS;
   localparam int HALF_CLOCKS = `MICRO_UART_BIT_CLOCKS / 2;
   localparam int COUNT_W     = $clog2(FULL_CLOCKS);

   logic [COUNT_W-1:0]          count;
   logic [COUNT_W-1:0]          last;
   micro_uart_pkg::timer_mode_t active_mode;

   // the mode is only taken at a restart, so a period in flight keeps its length.
   assign last = (active_mode == micro_uart_pkg::TIMER_HALF) ?
                 COUNT_W'(HALF_CLOCKS - 1) : COUNT_W'(FULL_CLOCKS - 1);

   assign tick = run & (count == last);

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         count       <= '0;
         active_mode <= micro_uart_pkg::TIMER_FULL;
      end else if (!run || tick) begin
         count       <= '0;
         active_mode <= mode;
      end else begin
         count <= count + 1'b1;
      end
   end

endmodule

//--- hw/micro_uart_fifo.sv
`include "micro_uart_cfg.svh"

module micro_uart_fifo #(
   parameter type payload_t = micro_uart_pkg::uart_byte_t
) (
   input  logic     clock,
   input  logic     clock_sreset,
   input  logic     push,
   input  payload_t wdata,
   input  logic     pop,
   output payload_t rdata,
   output logic     full,
   output logic     empty
);

   localparam int DEPTH = `MICRO_UART_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   payload_t           mem [DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               do_push;
   logic               do_pop;

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);
   assign rdata = mem[rd_ptr];

   // a push while full or a pop while empty is dropped.
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   always_ff @(posedge clock) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clock) begin
      if (clock_sreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // both served together leaves the count alone.
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- hw/micro_uart_pkg.sv
package micro_uart_pkg;

   // one character on the line.
   typedef logic [7:0] uart_byte_t;

   // entry of the receive fifo.
   // framing_error is set when the stop bit was sampled low.
   typedef struct packed {
      uart_byte_t data;
      logic       framing_error;
   } rx_frame_t;

   // distance to the next bit timer tick.
   typedef enum logic {
      TIMER_FULL = 1'b0,
      TIMER_HALF = 1'b1
   } timer_mode_t;

endpackage

//--- hw/micro_uart_cfg.svh
`ifndef MICRO_UART_CFG_SVH
`define MICRO_UART_CFG_SVH

// system clock feeding the whole block.
`define MICRO_UART_CLOCK_RATE_HZ 100000000

// serial line rate, both directions.
`define MICRO_UART_BAUD_RATE 10000000

// clocks per bit on the line.
`define MICRO_UART_BIT_CLOCKS (`MICRO_UART_CLOCK_RATE_HZ / `MICRO_UART_BAUD_RATE)

// entries in each of the transmit and receive fifos.
`define MICRO_UART_FIFO_DEPTH 4

`endif
